// File: logic/sd_phy_pkg.sv
/*
  sd phy package
  bus-level types for the SD card 4-bit DAT receive path,
  shared by the phy, the block framer and the testbench monitor
*/

package sd_phy_pkg;

  // number of DAT lines on the 4-bit bus
  localparam int NUM_LANES = 4;

  // one captured DAT nibble
  // valid pulses for one clk cycle per SD clock rising edge
  typedef struct packed {
    logic                 valid;
    logic [NUM_LANES-1:0] dat;
  } dat_sample_t;

endpackage

// File: logic/sd_block_pkg.sv
/*
  sd block package
  block-level types for the DAT receive path: framer states,
  per-lane bit steering, output byte stream and the CRC16 constants
*/

package sd_block_pkg;

  // framer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_CRC,
    ST_END_BIT
  } rx_state_e;

  // one bit steered to a single lane checker
  typedef struct packed {
    logic bit_val;   // DAT line value
    logic data_stb;  // bit belongs to the data phase
    logic crc_stb;   // bit belongs to the crc phase
    logic clr;       // block start, clears the checker
  } lane_bit_t;

  // CRC16 CCITT, x^16 + x^12 + x^5 + 1
  localparam logic [15:0] CRC16_POLY = 16'h1021;
  // crc bits per lane, also the number of crc nibbles per block
  localparam int CRC16_BITS = 16;

  // output stream beat
  typedef struct packed {
    logic [7:0] data;
    logic       last;  // final byte of the block
    logic       err;   // crc or end bit failure, only on the last byte
  } rx_byte_t;

endpackage

// File: logic/sd_dev_phy.sv
/*
  SD device phy, receive side
  samples the slow SD clock with the system clock, finds its rising
  edges and emits one DAT nibble per edge once the lock period is over
*/

`timescale 1ns/1ns

module sd_dev_phy import sd_phy_pkg::*; #(
  parameter int LOCK_CYCLES = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_phy_clk,
  input  logic [3:0]  i_phy_dat,
  output logic        o_locked,
  output dat_sample_t o_sample
);

  localparam int CW = $clog2(LOCK_CYCLES + 1);

  logic          prev_clk;
  logic          rise_q;
  logic [3:0]    dat_q;
  logic [CW-1:0] lock_cnt;

  // edge register, rise_q marks the clk edge that saw SD clock go high
  always_ff @(posedge clk) begin
    if (rst) begin
      prev_clk <= 1'b0;
      rise_q   <= 1'b0;
    end else begin
      prev_clk <= i_phy_clk;
      rise_q   <= i_phy_clk & ~prev_clk;
    end
  end

  // DAT value taken at the detection edge
  always_ff @(posedge clk) begin
    dat_q <= i_phy_dat;
  end

  // lock counter, o_locked rises LOCK_CYCLES cycles after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      lock_cnt <= '0;
      o_locked <= 1'b0;
    end else if (!o_locked) begin
      if (lock_cnt == CW'(LOCK_CYCLES - 1)) begin
        o_locked <= 1'b1;
      end else begin
        lock_cnt <= lock_cnt + 1'b1;
      end
    end
  end

  // sample output, quiet until locked
  always_ff @(posedge clk) begin
    if (rst) begin
      o_sample.valid <= 1'b0;
    end else begin
      o_sample.valid <= rise_q & o_locked;
    end
    o_sample.dat <= dat_q;
  end

endmodule

// File: logic/sd_block_framer.sv
/*
  SD DAT block framer
  finds the start bit, counts data and crc nibbles, steers bit k of each
  nibble to lane k, forwards data nibbles and checks the end bit
*/

`timescale 1ns/1ns

module sd_block_framer import sd_phy_pkg::*, sd_block_pkg::*; #(
  parameter int BLOCK_BYTES = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  dat_sample_t i_sample,
  input  logic        i_busy,
  output lane_bit_t   o_lane [NUM_LANES],
  output dat_sample_t o_nibble,
  output logic        o_block_end,
  output logic        o_end_ok
);

  localparam int DATA_NIBBLES = 2 * BLOCK_BYTES;
  // counter covers whichever phase is longer
  localparam int CNT_W = $clog2((DATA_NIBBLES > CRC16_BITS) ? DATA_NIBBLES : CRC16_BITS);

  rx_state_e        state;
  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_IDLE;
      cnt         <= '0;
      o_block_end <= 1'b0;
      o_end_ok    <= 1'b0;
      o_nibble.valid <= 1'b0;
      for (int k = 0; k < NUM_LANES; k++) begin
        o_lane[k].data_stb <= 1'b0;
        o_lane[k].crc_stb  <= 1'b0;
        o_lane[k].clr      <= 1'b0;
      end
    end else begin
      // strobes are single cycle
      o_block_end    <= 1'b0;
      o_nibble.valid <= 1'b0;
      for (int k = 0; k < NUM_LANES; k++) begin
        o_lane[k].data_stb <= 1'b0;
        o_lane[k].crc_stb  <= 1'b0;
        o_lane[k].clr      <= 1'b0;
      end
      if (i_sample.valid) begin
        case (state)
          ST_IDLE: begin
            // all four lines low is the start bit
            if (i_sample.dat == '0 && !i_busy) begin
              state <= ST_DATA;
              cnt   <= '0;
              for (int k = 0; k < NUM_LANES; k++) o_lane[k].clr <= 1'b1;
            end
          end
          ST_DATA: begin
            for (int k = 0; k < NUM_LANES; k++) o_lane[k].data_stb <= 1'b1;
            o_nibble.valid <= 1'b1;
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(DATA_NIBBLES - 1)) begin
              state <= ST_CRC;
              cnt   <= '0;
            end
          end
          ST_CRC: begin
            for (int k = 0; k < NUM_LANES; k++) o_lane[k].crc_stb <= 1'b1;
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(CRC16_BITS - 1)) state <= ST_END_BIT;
          end
          default: begin
            // end bit is high on every line
            o_block_end <= 1'b1;
            o_end_ok    <= (i_sample.dat == '1);
            state       <= ST_IDLE;
          end
        endcase
      end
    end
  end

  // payload, bit k goes to lane k
  always_ff @(posedge clk) begin
    if (i_sample.valid) begin
      o_nibble.dat <= i_sample.dat;
      for (int k = 0; k < NUM_LANES; k++) o_lane[k].bit_val <= i_sample.dat[k];
    end
  end

endmodule

// File: logic/sd_lane_crc16.sv
/*
  per-lane CRC16 checker
  serial CCITT CRC over one DAT line's data bits, then a bit by bit
  compare against the received crc, msb first
*/

`timescale 1ns/1ns

module sd_lane_crc16 import sd_block_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  lane_bit_t i_lane,
  output logic      o_crc_ok
);

  logic [CRC16_BITS-1:0] crc;
  logic                  mismatch;
  logic                  fb;

  // feedback of the serial lfsr
  assign fb = crc[CRC16_BITS-1] ^ i_lane.bit_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      crc      <= '0;
      mismatch <= 1'b0;
    end else if (i_lane.clr) begin
      // new block
      crc      <= '0;
      mismatch <= 1'b0;
    end else if (i_lane.data_stb) begin
      crc <= {crc[CRC16_BITS-2:0], 1'b0} ^ (fb ? CRC16_POLY : '0);
    end else if (i_lane.crc_stb) begin
      // compare with the current msb, then shift the next one up
      if (i_lane.bit_val != crc[CRC16_BITS-1]) begin
        mismatch <= 1'b1;
      end
      crc <= {crc[CRC16_BITS-2:0], 1'b0};
    end
  end

  // sticky until the next block start
  assign o_crc_ok = ~mismatch;

endmodule

// File: logic/sd_block_sink.sv
/*
  SD block sink
  packs nibbles into bytes, high nibble first, holds one block and
  streams it out on valid/ready with the error flag on the last byte
*/

`timescale 1ns/1ns

module sd_block_sink import sd_phy_pkg::*, sd_block_pkg::*; #(
  parameter int BLOCK_BYTES = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  dat_sample_t          i_nibble,
  input  logic                 i_block_end,
  input  logic                 i_end_ok,
  input  logic [NUM_LANES-1:0] i_crc_ok,
  output logic                 o_busy,
  output rx_byte_t             o_byte,
  output logic                 o_valid,
  input  logic                 i_ready
);

  localparam int IDX_W = $clog2(BLOCK_BYTES);

  logic [7:0]       mem [BLOCK_BYTES];
  logic [3:0]       hi_nib;
  logic             half;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             err_q;
  logic             last_byte;

  assign last_byte = (rd_idx == IDX_W'(BLOCK_BYTES - 1));

  // byte packing and block buffer
  always_ff @(posedge clk) begin
    if (i_nibble.valid) begin
      if (!half) hi_nib <= i_nibble.dat;
      else mem[wr_idx] <= {hi_nib, i_nibble.dat};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      half    <= 1'b0;
      wr_idx  <= '0;
      rd_idx  <= '0;
      err_q   <= 1'b0;
      o_busy  <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      if (i_nibble.valid) begin
        // busy from the first data nibble on
        o_busy <= 1'b1;
        half   <= ~half;
        if (half) wr_idx <= wr_idx + 1'b1;
      end
      if (i_block_end) begin
        // any bad lane crc or a missing end bit flags the block
        err_q   <= ~(&i_crc_ok & i_end_ok);
        half    <= 1'b0;
        wr_idx  <= '0;
        rd_idx  <= '0;
        o_valid <= 1'b1;
      end else if (o_valid && i_ready) begin
        if (last_byte) begin
          o_valid <= 1'b0;
          o_busy  <= 1'b0;
        end else begin
          rd_idx <= rd_idx + 1'b1;
        end
      end
    end
  end

  // read port, stable while rd_idx holds
  assign o_byte.data = mem[rd_idx];
  assign o_byte.last = last_byte;
  assign o_byte.err  = last_byte & err_q;

endmodule

// File: logic/sd_dev_rx_top.sv
/*
  SD device DAT receive top
  phy, block framer, four per-lane CRC16 checkers and the block sink,
  delivering host write blocks as a byte stream
*/

`timescale 1ns/1ns

module sd_dev_rx_top import sd_phy_pkg::*, sd_block_pkg::*; #(
  parameter int BLOCK_BYTES = 8,
  parameter int LOCK_CYCLES = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_phy_clk,
  input  logic [3:0] i_phy_dat,
  output logic       o_locked,
  output logic       o_busy,
  output rx_byte_t   o_byte,
  output logic       o_valid,
  input  logic       i_ready
);

  dat_sample_t          sample;
  dat_sample_t          nibble;
  lane_bit_t            lane_bits [NUM_LANES];
  logic [NUM_LANES-1:0] crc_ok;
  logic                 block_end;
  logic                 end_ok;

  sd_dev_phy #(
    .LOCK_CYCLES (LOCK_CYCLES)
  ) u_phy (
    .clk       (clk),
    .rst       (rst),
    .i_phy_clk (i_phy_clk),
    .i_phy_dat (i_phy_dat),
    .o_locked  (o_locked),
    .o_sample  (sample)
  );

  sd_block_framer #(
    .BLOCK_BYTES (BLOCK_BYTES)
  ) u_framer (
    .clk         (clk),
    .rst         (rst),
    .i_sample    (sample),
    .i_busy      (o_busy),
    .o_lane      (lane_bits),
    .o_nibble    (nibble),
    .o_block_end (block_end),
    .o_end_ok    (end_ok)
  );

  // one checker per DAT line
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    sd_lane_crc16 u_crc (
      .clk      (clk),
      .rst      (rst),
      .i_lane   (lane_bits[g]),
      .o_crc_ok (crc_ok[g])
    );
  end

  sd_block_sink #(
    .BLOCK_BYTES (BLOCK_BYTES)
  ) u_sink (
    .clk         (clk),
    .rst         (rst),
    .i_nibble    (nibble),
    .i_block_end (block_end),
    .i_end_ok    (end_ok),
    .i_crc_ok    (crc_ok),
    .o_busy      (o_busy),
    .o_byte      (o_byte),
    .o_valid     (o_valid),
    .i_ready     (i_ready)
  );

endmodule

// File: tb/sd_dev_rx_assertions.sv
/*
  SD receive top assertions
  output handshake, lock gating and reset state of the top level
*/

`timescale 1ns/1ns

module sd_dev_rx_assertions import sd_block_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     i_locked,
  input logic     i_sample_valid,
  input logic     i_busy,
  input logic     i_valid,
  input logic     i_ready,
  input rx_byte_t i_byte
);

  // count of failed assertions
  int fail_count = 0;

  // a stalled beat keeps valid high and its data unchanged
  a_hold: assert property (@(posedge clk) disable iff (rst)
    i_valid && !i_ready |=> i_valid && $stable(i_byte))
    else begin
      fail_count++;
      $error("output beat dropped or changed while stalled");
    end

  // no DAT sample and no byte leave before the phy has locked
  a_lock: assert property (@(posedge clk) disable iff (rst)
    !i_locked |-> !i_sample_valid && !i_valid)
    else begin
      fail_count++;
      $error("DAT sample or output valid before lock");
    end

  // reset clears valid, busy and lock
  a_reset: assert property (@(posedge clk) rst |=> !i_valid && !i_busy && !i_locked)
    else begin
      fail_count++;
      $error("outputs not cleared by reset");
    end

endmodule

bind sd_dev_rx_top sd_dev_rx_assertions u_sva (
  .clk            (clk),
  .rst            (rst),
  .i_locked       (o_locked),
  .i_sample_valid (sample.valid),
  .i_busy         (o_busy),
  .i_valid        (o_valid),
  .i_ready        (i_ready),
  .i_byte         (o_byte)
);

// File: tb/tb_sd_dev_rx.sv
/*
  testbench for the SD device DAT receive path
  drives host write blocks on the 4-bit bus with a reference CRC16,
  checks the byte stream against a scoreboard queue
*/

`timescale 1ns/1ns

module tb_sd_dev_rx import sd_phy_pkg::*, sd_block_pkg::*; ();

  localparam int BLOCK_BYTES = 8;
  localparam int LOCK_CYCLES = 16;
  localparam int NUM_BLOCKS  = 14;
  // nibbles per block with start, crc, end and idle, 8 clk per SD period, x2 margin
  localparam int WATCHDOG_CYCLES = NUM_BLOCKS * (BLOCK_BYTES * 2 + 20) * 8 * 2 + 2000;

  logic       clk;
  logic       rst;
  logic       phy_clk;
  logic [3:0] phy_dat;
  logic       ready;
  logic       locked;
  logic       busy;
  logic       valid;
  rx_byte_t   rx_byte;

  int         ready_mode = 0;  // 0 always ready, 1 random, 2 stalled
  int         checks = 0;
  int         errors = 0;
  rx_byte_t   expected [$];

  sd_dev_rx_top #(
    .BLOCK_BYTES (BLOCK_BYTES),
    .LOCK_CYCLES (LOCK_CYCLES)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .i_phy_clk (phy_clk),
    .i_phy_dat (phy_dat),
    .o_locked  (locked),
    .o_busy    (busy),
    .o_byte    (rx_byte),
    .o_valid   (valid),
    .i_ready   (ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // SD spec CRC16 of one DAT line, G(x) = x^16 + x^12 + x^5 + 1
  function automatic logic [15:0] lane_crc16_ref(input logic [7:0] data [BLOCK_BYTES],
                                                 input int lane);
    logic [15:0] crc;
    logic        b;
    crc = 16'h0000;
    for (int i = 0; i < BLOCK_BYTES * 2; i++) begin
      // high nibble of each byte goes first on the bus
      b = (i % 2 == 0) ? data[i / 2][lane + 4] : data[i / 2][lane];
      crc = (crc[15] ^ b) ? ({crc[14:0], 1'b0} ^ 16'h1021) : {crc[14:0], 1'b0};
    end
    return crc;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (exp == got) else begin
      errors++;
      $display("CHECK FAILED %s expected %h got %h", name, exp, got);
    end
  endtask

  // one SD clock period, DAT changes while the SD clock is low
  task automatic drive_sd_period(input logic [3:0] nib);
    phy_clk = 1'b0;
    phy_dat = nib;
    repeat (4) @(negedge clk);
    phy_clk = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic wait_idle();
    while (busy) @(negedge clk);
  endtask

  task automatic wait_drained();
    while (expected.size() != 0 || busy) @(negedge clk);
  endtask

  // o_locked must rise on exactly the LOCK_CYCLES-th edge after reset
  task automatic check_lock();
    for (int i = 1; i <= LOCK_CYCLES; i++) begin
      @(negedge clk);
      check_value("o_locked", 32'(i == LOCK_CYCLES), 32'(locked));
    end
  endtask

  // start nibble, data, per-lane crc, end nibble and one idle period
  task automatic send_block(input bit expect_rx, input int bad_lane, input bit bad_end);
    logic [7:0]  data [BLOCK_BYTES];
    logic [15:0] crc [NUM_LANES];
    logic [3:0]  nib;
    rx_byte_t    beat;
    for (int i = 0; i < BLOCK_BYTES; i++) data[i] = 8'($urandom);
    for (int k = 0; k < NUM_LANES; k++) crc[k] = lane_crc16_ref(data, k);
    // one flipped bit spoils that lane's crc
    if (bad_lane >= 0) crc[bad_lane] = crc[bad_lane] ^ (16'h1 << ($urandom % 16));
    if (expect_rx) begin
      wait_idle();
      for (int i = 0; i < BLOCK_BYTES; i++) begin
        beat.data = data[i];
        beat.last = (i == BLOCK_BYTES - 1);
        beat.err  = beat.last && (bad_lane >= 0 || bad_end);
        expected.push_back(beat);
      end
    end
    drive_sd_period(4'h0);
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      drive_sd_period(data[i][7:4]);
      drive_sd_period(data[i][3:0]);
    end
    // crc msb first, bit k of each nibble from lane k
    for (int b = 15; b >= 0; b--) begin
      for (int k = 0; k < NUM_LANES; k++) nib[k] = crc[k][b];
      drive_sd_period(nib);
    end
    drive_sd_period(bad_end ? 4'h0 : 4'hF);
    drive_sd_period(4'hF);
  endtask

  task automatic take_output();
    rx_byte_t exp;
    checks++;
    assert (expected.size() != 0) else begin
      errors++;
      $display("output byte %h arrived with no block pending", rx_byte.data);
    end
    if (expected.size() != 0) begin
      exp = expected.pop_front();
      check_value("o_byte.data", 32'(exp.data), 32'(rx_byte.data));
      check_value("o_byte.last", 32'(exp.last), 32'(rx_byte.last));
      check_value("o_byte.err", 32'(exp.err), 32'(rx_byte.err));
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, i_dut.u_sva.fail_count);
  endtask

  // ready set on the falling edge, the beat read 1 ns later while stable
  initial begin
    ready = 1'b0;
    forever begin
      @(negedge clk);
      ready = (ready_mode == 0) || (ready_mode == 1 && ($urandom % 3) != 0);
      #1;
      if (valid && ready) take_output();
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    report_counts();
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h1572_3b9a));
    rst     = 1'b1;
    phy_clk = 1'b0;
    phy_dat = 4'hF;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    // start bit inside the lock window, later nibbles are not start bits
    fork
      check_lock();
      begin
        drive_sd_period(4'h0);
        drive_sd_period(4'hA);
        drive_sd_period(4'h5);
      end
    join
    checks++;
    assert (!busy && !valid) else begin
      errors++;
      $display("start bit sent before lock opened a block");
    end
    send_block(1, -1, 0);
    for (int k = 0; k < NUM_LANES; k++) send_block(1, k, 0);
    send_block(1, -1, 1);
    ready_mode = 1;
    for (int n = 0; n < 4; n++) send_block(1, -1, 0);
    wait_drained();
    // first block is held in the sink, the second is dropped
    ready_mode = 2;
    send_block(1, -1, 0);
    checks++;
    assert (busy) else begin
      errors++;
      $display("sink not busy while holding a stalled block");
    end
    send_block(0, -1, 0);
    ready_mode = 0;
    send_block(1, -1, 0);
    wait_drained();
    repeat (4) @(negedge clk);
    report_counts();
    if (errors == 0 && i_dut.u_sva.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: project.f
logic/sd_phy_pkg.sv
logic/sd_block_pkg.sv
logic/sd_dev_phy.sv
logic/sd_block_framer.sv
logic/sd_lane_crc16.sv
logic/sd_block_sink.sv
logic/sd_dev_rx_top.sv
tb/sd_dev_rx_assertions.sv
tb/tb_sd_dev_rx.sv

// File: run.sh
#!/bin/sh
# build and run the SD receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_sd_dev_rx -f project.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_sd_dev_rx +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
